/* hdl/wca_settings.svh */
/*
 * Weight cache build constants
 * Port count, address and data widths, store depth
 */

`ifndef WCA_SETTINGS_SVH
`define WCA_SETTINGS_SVH

// Processing-element ports
`define WCA_NUM_PORTS 4

// Weight address and word widths
`define WCA_ADDR_W 13
`define WCA_DATA_W 8

// log2 of the store depth, 32 slots
`define WCA_ENTRY_W 5

`endif

/* hdl/wca_pkg.sv */
/*
 * Weight cache package
 * Address, data, port and slot types
 * Controller state and mode enums
 */

`include "wca_settings.svh"

package wca_pkg;

    typedef logic [`WCA_ADDR_W-1:0]  addr_t;
    typedef logic [`WCA_DATA_W-1:0]  data_t;
    typedef logic [1:0]              port_idx_t;   // Four ports
    typedef logic [`WCA_ENTRY_W-1:0] entry_idx_t;

    // Configuration FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CFG  = 2'd1,
        ST_WORK = 2'd2
    } wca_state_e;

    // Mode latched when entering work
    typedef enum logic {
        MODE_BYPASS = 1'b0,
        MODE_CACHE  = 1'b1
    } wca_mode_e;

endpackage

/* hdl/wca_ctrl.sv */
/*
 * Weight cache controller
 * Idle, config and work FSM with mode latch and store clear
 */

`timescale 1ns/1ps

module wca_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_info_vld,
    input  logic                cfg_wbuf_ena,
    output logic                cfg_info_rdy,
    output logic                work,
    output wca_pkg::wca_mode_e  mode,
    output logic                clear
);

    import wca_pkg::*;

    wca_state_e state;
    wca_state_e next_state;

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: if (cfg_info_vld) next_state = ST_CFG;
            ST_CFG:  next_state = ST_WORK;            // Single config cycle
            ST_WORK: if (cfg_info_vld) next_state = ST_IDLE;
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Mode taken on the config to work edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_BYPASS;
        end else if (state == ST_CFG) begin
            mode <= cfg_wbuf_ena ? MODE_CACHE : MODE_BYPASS;
        end
    end

    assign cfg_info_rdy = (state == ST_IDLE);
    assign work         = (state == ST_WORK);
    assign clear        = (state == ST_IDLE);     // Store and fetch flush

endmodule

/* hdl/wca_hit_array.sv */
/*
 * Tagged weight store
 * 32 slots of tag, word and valid bit
 * Per-port lookup, lowest matching slot wins
 * Fill at a rotating pointer on each returned word
 */

`timescale 1ns/1ps

`include "wca_settings.svh"

module wca_hit_array (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clear,
    input  logic                                  work,
    input  wca_pkg::wca_mode_e                    mode,
    input  wca_pkg::addr_t [`WCA_NUM_PORTS-1:0]   req_addr,
    input  logic                                  fill_en,
    input  wca_pkg::addr_t                        fill_addr,
    input  wca_pkg::data_t                        fill_data,
    output logic [`WCA_NUM_PORTS-1:0]             hit,
    output wca_pkg::data_t [`WCA_NUM_PORTS-1:0]   hit_data
);

    import wca_pkg::*;

    localparam int DEPTH = 1 << `WCA_ENTRY_W;

    addr_t                       slot_tag  [DEPTH];
    data_t                       slot_data [DEPTH];
    logic [DEPTH-1:0]            slot_vld;
    entry_idx_t                  fill_ptr;
    logic [`WCA_NUM_PORTS-1:0]   match;
    logic                        cache_on;
    logic                        fill_wr;

    assign cache_on = work && (mode == MODE_CACHE);
    assign fill_wr  = fill_en && cache_on;

    // ==============================
    // Lookup
    // ==============================
    // Scan from the top so the lowest matching slot is the last one written
    always_comb begin
        for (int p = 0; p < `WCA_NUM_PORTS; p++) begin
            match[p]    = 1'b0;
            hit_data[p] = '0;
            for (int s = DEPTH - 1; s >= 0; s--) begin
                if (slot_vld[s] && (slot_tag[s] == req_addr[p])) begin
                    match[p]    = 1'b1;
                    hit_data[p] = slot_data[s];
                end
            end
        end
    end

    assign hit = match & {`WCA_NUM_PORTS{cache_on}};   // No hits in bypass or outside work

    // ==============================
    // Fill
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
            fill_ptr <= '0;
        end else if (clear) begin
            slot_vld <= '0;
            fill_ptr <= '0;
        end else if (fill_wr) begin
            slot_vld[fill_ptr] <= 1'b1;
            fill_ptr           <= fill_ptr + entry_idx_t'(1);   // Wraps over the oldest slot
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr) begin
            slot_tag[fill_ptr]  <= fill_addr;
            slot_data[fill_ptr] <= fill_data;
        end
    end

endmodule

/* hdl/wca_arbiter.sv */
/*
 * Miss arbiter and weight-buffer read control
 * Round-robin grant, one read outstanding at a time
 * Per-port accept, load strobe and source select
 */

`timescale 1ns/1ps

`include "wca_settings.svh"

module wca_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clear,
    input  logic                                  work,
    input  logic [`WCA_NUM_PORTS-1:0]             req_vld,
    input  wca_pkg::addr_t [`WCA_NUM_PORTS-1:0]   req_addr,
    input  logic [`WCA_NUM_PORTS-1:0]             hit,
    input  logic [`WCA_NUM_PORTS-1:0]             slot_free,
    output logic [`WCA_NUM_PORTS-1:0]             req_rdy,
    output logic [`WCA_NUM_PORTS-1:0]             load,
    output logic [`WCA_NUM_PORTS-1:0]             load_sel_ret,
    output wca_pkg::data_t                        load_ret_data,
    output logic                                  wbuf_add_vld,
    output wca_pkg::addr_t                        wbuf_add_addr,
    input  logic                                  wbuf_add_rdy,
    input  logic                                  wbuf_dat_vld,
    input  wca_pkg::data_t                        wbuf_dat_data,
    output logic                                  wbuf_dat_rdy,
    output logic                                  fill_en,
    output wca_pkg::addr_t                        fill_addr
);

    import wca_pkg::*;

    logic [`WCA_NUM_PORTS-1:0] miss;
    port_idx_t                 rr_ptr;       // Last granted port
    port_idx_t                 grant;
    port_idx_t                 pick;
    logic                      pick_vld;
    logic                      pick_en;
    logic                      pend_add;     // Address waiting for the buffer
    logic                      outstanding;  // Address taken, word not yet back
    addr_t                     issue_addr;
    logic                      ret_xfer;

    assign miss = req_vld & ~hit & {`WCA_NUM_PORTS{work}};

    // Search starts one past the last grant, nearest candidate wins
    always_comb begin
        port_idx_t cand;
        pick_vld = 1'b0;
        pick     = rr_ptr;
        for (int i = `WCA_NUM_PORTS; i >= 1; i--) begin
            cand = port_idx_t'(rr_ptr + i);
            if (miss[cand]) begin
                pick_vld = 1'b1;
                pick     = cand;
            end
        end
    end

    assign pick_en = work && pick_vld && !pend_add && !outstanding;

    // ==============================
    // Fetch tracking
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_add    <= 1'b0;
            outstanding <= 1'b0;
            rr_ptr      <= '0;
            grant       <= '0;
        end else if (clear) begin
            pend_add    <= 1'b0;
            outstanding <= 1'b0;
        end else if (pick_en) begin
            pend_add <= 1'b1;
            grant    <= pick;
            rr_ptr   <= pick;
        end else if (pend_add && wbuf_add_rdy) begin
            pend_add    <= 1'b0;
            outstanding <= 1'b1;
        end else if (ret_xfer) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_en) begin
            issue_addr <= req_addr[pick];
        end
    end

    assign wbuf_add_vld  = pend_add;
    assign wbuf_add_addr = issue_addr;
    assign wbuf_dat_rdy  = outstanding && slot_free[grant];   // Stall while the port is full
    assign ret_xfer      = wbuf_dat_vld && wbuf_dat_rdy;

    // ==============================
    // Port accept and load
    // ==============================
    always_comb begin
        for (int p = 0; p < `WCA_NUM_PORTS; p++) begin
            load_sel_ret[p] = ret_xfer && (grant == port_idx_t'(p));
            req_rdy[p]      = (hit[p] && slot_free[p]) || load_sel_ret[p];
        end
    end

    assign load          = req_vld & req_rdy;
    assign load_ret_data = wbuf_dat_data;
    assign fill_en       = ret_xfer;     // Store keeps it only in cache mode
    assign fill_addr     = issue_addr;

endmodule

/* hdl/wca_port_out.sv */
/*
 * Per-port response register
 * One entry with valid/ready, loads a store word or a returned word
 */

`timescale 1ns/1ps

module wca_port_out (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear,
    input  logic            load,
    input  logic            load_sel_ret,
    input  wca_pkg::data_t  hit_data,
    input  wca_pkg::data_t  ret_data,
    output logic            rsp_vld,
    output wca_pkg::data_t  rsp_data,
    input  logic            rsp_rdy,
    output logic            slot_free
);

    // Empty, or the held word leaves this cycle
    assign slot_free = !rsp_vld || rsp_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else if (clear) begin
            rsp_vld <= 1'b0;
        end else if (load) begin
            rsp_vld <= 1'b1;
        end else if (rsp_rdy) begin
            rsp_vld <= 1'b0;     // Drained
        end
    end

    // Word source picked by the arbiter
    always_ff @(posedge clk) begin
        if (load) begin
            rsp_data <= load_sel_ret ? ret_data : hit_data;
        end
    end

endmodule

/* hdl/weight_cache.sv */
/*
 * Weight cache top level
 * Controller, tagged store, miss arbiter and four response registers
 */

`timescale 1ns/1ps

`include "wca_settings.svh"

module weight_cache (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic                                  cfg_info_vld,
    input  logic                                  cfg_wbuf_ena,
    output logic                                  cfg_info_rdy,

    input  logic [`WCA_NUM_PORTS-1:0]             req_vld,
    input  wca_pkg::addr_t [`WCA_NUM_PORTS-1:0]   req_addr,
    output logic [`WCA_NUM_PORTS-1:0]             req_rdy,

    output logic [`WCA_NUM_PORTS-1:0]             rsp_vld,
    output wca_pkg::data_t [`WCA_NUM_PORTS-1:0]   rsp_data,
    input  logic [`WCA_NUM_PORTS-1:0]             rsp_rdy,

    output logic                                  wbuf_add_vld,
    output wca_pkg::addr_t                        wbuf_add_addr,
    input  logic                                  wbuf_add_rdy,

    input  logic                                  wbuf_dat_vld,
    input  wca_pkg::data_t                        wbuf_dat_data,
    output logic                                  wbuf_dat_rdy
);

    import wca_pkg::*;

    logic                        work;
    wca_mode_e                   mode;
    logic                        clear;
    logic [`WCA_NUM_PORTS-1:0]   hit;
    data_t [`WCA_NUM_PORTS-1:0]  hit_data;
    logic [`WCA_NUM_PORTS-1:0]   slot_free;
    logic [`WCA_NUM_PORTS-1:0]   load;
    logic [`WCA_NUM_PORTS-1:0]   load_sel_ret;
    data_t                       load_ret_data;
    logic                        fill_en;
    addr_t                       fill_addr;

    wca_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_info_vld (cfg_info_vld),
        .cfg_wbuf_ena (cfg_wbuf_ena),
        .cfg_info_rdy (cfg_info_rdy),
        .work         (work),
        .mode         (mode),
        .clear        (clear)
    );

    wca_hit_array u_hit_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .work      (work),
        .mode      (mode),
        .req_addr  (req_addr),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (load_ret_data),   // Returned word goes to the store too
        .hit       (hit),
        .hit_data  (hit_data)
    );

    wca_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .work          (work),
        .req_vld       (req_vld),
        .req_addr      (req_addr),
        .hit           (hit),
        .slot_free     (slot_free),
        .req_rdy       (req_rdy),
        .load          (load),
        .load_sel_ret  (load_sel_ret),
        .load_ret_data (load_ret_data),
        .wbuf_add_vld  (wbuf_add_vld),
        .wbuf_add_addr (wbuf_add_addr),
        .wbuf_add_rdy  (wbuf_add_rdy),
        .wbuf_dat_vld  (wbuf_dat_vld),
        .wbuf_dat_data (wbuf_dat_data),
        .wbuf_dat_rdy  (wbuf_dat_rdy),
        .fill_en       (fill_en),
        .fill_addr     (fill_addr)
    );

    // ==============================
    // Response registers
    // ==============================
    for (genvar g = 0; g < `WCA_NUM_PORTS; g++) begin : g_port
        wca_port_out u_port_out (
            .clk          (clk),
            .rst_n        (rst_n),
            .clear        (clear),
            .load         (load[g]),
            .load_sel_ret (load_sel_ret[g]),
            .hit_data     (hit_data[g]),
            .ret_data     (load_ret_data),
            .rsp_vld      (rsp_vld[g]),
            .rsp_data     (rsp_data[g]),
            .rsp_rdy      (rsp_rdy[g]),
            .slot_free    (slot_free[g])
        );
    end

endmodule

/* tb/wca_asserts.sv */
/*
 * Weight cache handshake assertions
 * Response and read-address hold, single outstanding fetch,
 * configuration ready only in idle
 */

`timescale 1ns/1ps

`include "wca_settings.svh"

module wca_asserts (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cfg_info_vld,
    input  logic                                  cfg_info_rdy,
    input  logic [`WCA_NUM_PORTS-1:0]             rsp_vld,
    input  wca_pkg::data_t [`WCA_NUM_PORTS-1:0]   rsp_data,
    input  logic [`WCA_NUM_PORTS-1:0]             rsp_rdy,
    input  logic                                  wbuf_add_vld,
    input  wca_pkg::addr_t                        wbuf_add_addr,
    input  logic                                  wbuf_add_rdy,
    input  logic                                  wbuf_dat_vld,
    input  logic                                  wbuf_dat_rdy
);

    int   assert_fails = 0;
    logic fetch_open;        // Address taken and word not back yet
    logic idle_m;            // Idle as seen from the configuration handshake
    logic cfg_m;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_open <= 1'b0;
        end else if (cfg_info_rdy) begin
            fetch_open <= 1'b0;                  // Idle flushes the fetch
        end else if (wbuf_add_vld && wbuf_add_rdy) begin
            fetch_open <= 1'b1;
        end else if (wbuf_dat_vld && wbuf_dat_rdy) begin
            fetch_open <= 1'b0;
        end
    end

    // Idle, one config cycle, then work until the next cfg_info_vld
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_m <= 1'b1;
            cfg_m  <= 1'b0;
        end else if (idle_m) begin
            if (cfg_info_vld) begin
                idle_m <= 1'b0;
                cfg_m  <= 1'b1;
            end
        end else if (cfg_m) begin
            cfg_m <= 1'b0;
        end else if (cfg_info_vld) begin
            idle_m <= 1'b1;
        end
    end

    // ==============================
    // Hold under back-pressure
    // ==============================
    for (genvar p = 0; p < `WCA_NUM_PORTS; p++) begin : g_rsp
        rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (rsp_vld[p] && !rsp_rdy[p]) |=> (rsp_vld[p] && $stable(rsp_data[p])))
        else begin
            $error("rsp_vld or rsp_data moved under back-pressure on port %0d", p);
            assert_fails++;
        end
    end

    add_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wbuf_add_vld && !wbuf_add_rdy) |=> (wbuf_add_vld && $stable(wbuf_add_addr)))
    else begin
        $error("wbuf_add_vld or wbuf_add_addr moved before the buffer took it");
        assert_fails++;
    end

    one_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_open |-> !wbuf_add_vld)
    else begin
        $error("second read address raised while a fetch is outstanding");
        assert_fails++;
    end

    idle_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_info_rdy == idle_m)
    else begin
        $error("cfg_info_rdy does not match the idle state");
        assert_fails++;
    end

endmodule

bind weight_cache wca_asserts u_asserts (.*);

/* tb/tb_weight_cache.sv */
/*
 * Weight cache testbench
 * Clock, reset, random port traffic and a weight-buffer model
 * Reference model with per-port response queues, store model and read counts
 * Compare tasks and a cycle-count timeout
 */

`timescale 1ns/1ps

`include "wca_settings.svh"

module tb_weight_cache;

    import wca_pkg::*;

    localparam int NP        = `WCA_NUM_PORTS;
    localparam int DEPTH     = 1 << `WCA_ENTRY_W;
    localparam int TOTAL_REQ = 800;      // Sum over all phases
    localparam int WORST_LAT = 12;       // Grant, address wait, 4 latency, drain
    localparam int MAX_CYC   = 4 * TOTAL_REQ * WORST_LAT;

    logic            clk;
    logic            rst_n;
    logic            cfg_info_vld;
    logic            cfg_wbuf_ena;
    logic            cfg_info_rdy;
    logic [NP-1:0]   req_vld;
    addr_t [NP-1:0]  req_addr;
    logic [NP-1:0]   req_rdy;
    logic [NP-1:0]   rsp_vld;
    data_t [NP-1:0]  rsp_data;
    logic [NP-1:0]   rsp_rdy;
    logic            wbuf_add_vld;
    addr_t           wbuf_add_addr;
    logic            wbuf_add_rdy;
    logic            wbuf_dat_vld;
    data_t           wbuf_dat_data;
    logic            wbuf_dat_rdy;

    integer seed = 79798;
    int     errors;
    int     checks;
    int     cycles;

    // Phase knobs
    logic run;
    logic bp_on;
    logic cache_mode;
    int   n_req;
    int   pool_n;
    int   pool_base;
    int   pool_step;
    int   issued;
    int   rsp_cnt;
    int   act_reads;
    int   exp_reads;
    int   distinct;

    // Reference model
    data_t             exp_q [NP][$];
    logic [NP-1:0]     acc;
    addr_t             st_tag [DEPTH];
    logic [DEPTH-1:0]  st_vld;
    int                fptr;
    addr_t             ret_addr;         // Address of the miss served by a return
    bit                seen [1 << `WCA_ADDR_W];

    // Weight-buffer model
    addr_t buf_addr;
    int    lat_cnt;
    logic  dat_done;

    weight_cache dut0 (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Word stored in the buffer at a given address
    function automatic data_t buf_word(addr_t a);
        return data_t'(a) ^ 8'h5A;
    endfunction

    function automatic logic in_store(addr_t a);
        for (int s = 0; s < DEPTH; s++) begin
            if (st_vld[s] && (st_tag[s] == a)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_data(data_t act, data_t exp, string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %h expected %h", $time, msg, act, exp);
        end
    endtask

    task automatic check_addr(addr_t act, addr_t exp, string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %h expected %h", $time, msg, act, exp);
        end
    endtask

    task automatic check_count(int act, int exp, string msg);
        checks++;
        if (act != exp) begin
            errors++;
            $display("error at %0t ns: %s, got %0d expected %0d", $time, msg, act, exp);
        end
    endtask

    task automatic check_rdy(logic act, logic exp, string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %b expected %b", $time, msg, act, exp);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYC) begin
            $display("timeout: run stopped after %0d cycles, responses still missing", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ==============================
    // Monitor and reference model
    // ==============================
    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (rsp_vld[p] && rsp_rdy[p]) begin
                    if (exp_q[p].size() == 0) begin
                        errors++;
                        $display("port %0d returned a word with no request pending", p);
                    end else begin
                        check_data(rsp_data[p], exp_q[p].pop_front(),
                                   $sformatf("port %0d response", p));
                    end
                    rsp_cnt++;
                end
                if (req_vld[p] && req_rdy[p]) begin
                    exp_q[p].push_back(buf_word(req_addr[p]));
                    if (!in_store(req_addr[p])) begin
                        exp_reads++;             // A miss costs one read
                        check_addr(buf_addr, req_addr[p],
                                   $sformatf("port %0d read address", p));
                        ret_addr = req_addr[p];
                    end
                    if (!seen[req_addr[p]]) begin
                        seen[req_addr[p]] = 1'b1;
                        distinct++;
                    end
                    acc[p] = 1'b1;
                end
            end
            if (wbuf_add_vld && wbuf_add_rdy) begin
                act_reads++;
                buf_addr = wbuf_add_addr;
                lat_cnt  = 1 + ({$random(seed)} % 4);
            end
            if (wbuf_dat_vld && wbuf_dat_rdy) begin
                if (cache_mode) begin
                    st_tag[fptr] = ret_addr;     // Rotating fill
                    st_vld[fptr] = 1'b1;
                    fptr         = (fptr + 1) % DEPTH;
                end
                dat_done = 1'b1;
            end
        end
    end

    // Stimulus and buffer responses on the falling edge
    always @(negedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (acc[p]) begin
                req_vld[p] = 1'b0;
                acc[p]     = 1'b0;
            end
            if (run) begin
                if (!req_vld[p] && (issued < n_req) && ($random(seed) & 1)) begin
                    req_vld[p]  = 1'b1;
                    req_addr[p] = addr_t'(pool_base + pool_step * ({$random(seed)} % pool_n));
                    issued++;
                end
                rsp_rdy[p] = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
            end
        end
        if (run) begin
            wbuf_add_rdy = ($random(seed) & 3) != 0;
        end
        if (dat_done) begin
            wbuf_dat_vld = 1'b0;
            dat_done     = 1'b0;
        end
        if (lat_cnt > 0) begin
            lat_cnt--;
            if (lat_cnt == 0) begin
                wbuf_dat_vld  = 1'b1;
                wbuf_dat_data = buf_word(buf_addr);
            end
        end
    end

    // Configure, run one traffic phase, check counts, return to idle
    task automatic run_phase(logic cache, int reqs, int pn, int base, int step, logic bp,
                             string name);
        @(negedge clk);
        check_rdy(cfg_info_rdy, 1'b1, {name, ": cfg_info_rdy before config"});
        cfg_info_vld = 1'b1;
        cfg_wbuf_ena = cache;
        @(negedge clk);
        cfg_info_vld = 1'b0;
        cache_mode   = cache;
        n_req        = reqs;
        pool_n       = pn;
        pool_base    = base;
        pool_step    = step;
        bp_on        = bp;
        issued       = 0;
        rsp_cnt      = 0;
        act_reads    = 0;
        exp_reads    = 0;
        distinct     = 0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        @(posedge clk);
        run = 1'b1;
        while (rsp_cnt < n_req) begin
            @(negedge clk);
        end
        @(posedge clk);
        run = 1'b0;
        check_count(act_reads, exp_reads, {name, ": buffer reads against store model"});
        if (!cache) begin
            check_count(act_reads, n_req, {name, ": buffer reads against requests"});
        end else if (pn <= DEPTH) begin
            check_count(act_reads, distinct, {name, ": buffer reads against distinct"});
        end
        @(negedge clk);
        cfg_info_vld = 1'b1;                     // Work back to idle
        @(negedge clk);
        cfg_info_vld = 1'b0;
        st_vld       = '0;
        fptr         = 0;
        check_rdy(cfg_info_rdy, 1'b1, {name, ": cfg_info_rdy after leaving work"});
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        rst_n         = 1'b0;
        cfg_info_vld  = 1'b0;
        cfg_wbuf_ena  = 1'b0;
        req_vld       = '0;
        req_addr      = '0;
        rsp_rdy       = '0;
        wbuf_add_rdy  = 1'b0;
        wbuf_dat_vld  = 1'b0;
        wbuf_dat_data = '0;
        run           = 1'b0;
        bp_on         = 1'b0;
        cache_mode    = 1'b0;
        acc           = '0;
        st_vld        = '0;
        fptr          = 0;
        ret_addr      = '0;
        lat_cnt       = 0;
        dat_done      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_rdy(cfg_info_rdy, 1'b1, "cfg_info_rdy after reset");
        check_rdy(wbuf_add_vld, 1'b0, "wbuf_add_vld after reset");
        check_rdy(wbuf_dat_rdy, 1'b0, "wbuf_dat_rdy after reset");
        for (int p = 0; p < NP; p++) begin
            check_rdy(req_rdy[p], 1'b0, $sformatf("req_rdy[%0d] after reset", p));
            check_rdy(rsp_vld[p], 1'b0, $sformatf("rsp_vld[%0d] after reset", p));
        end

        run_phase(1'b0, 200, 8192, 0, 1, 1'b0, "bypass");
        run_phase(1'b1, 200, 24, 16, 37, 1'b1, "cache");
        run_phase(1'b1, 100, 24, 16, 37, 1'b0, "cache after clear");   // Same pool
        run_phase(1'b1, 300, 48, 700, 53, 1'b1, "eviction");

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.u_asserts.assert_fails);
        if ((errors == 0) && (dut0.u_asserts.assert_fails == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/wca_pkg.sv
hdl/wca_ctrl.sv
hdl/wca_hit_array.sv
hdl/wca_arbiter.sv
hdl/wca_port_out.sv
hdl/weight_cache.sv
tb/wca_asserts.sv
tb/tb_weight_cache.sv

/* Bender.yml */
package:
  name: weight_cache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wca_pkg.sv
      - hdl/wca_ctrl.sv
      - hdl/wca_hit_array.sv
      - hdl/wca_arbiter.sv
      - hdl/wca_port_out.sv
      - hdl/weight_cache.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/wca_asserts.sv
      - tb/tb_weight_cache.sv
